/* Makefile */
VERILATOR ?= verilator
TOP       ?= race_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* list.f */
rtl/race_pkg.sv
rtl/key_decoder.sv
rtl/tick_gen.sv
rtl/player_car.sv
rtl/obstacle_field.sv
rtl/crash_monitor.sv
rtl/race_top.sv
tests/race_chk.sv
tests/race_tb.sv

/* rtl/crash_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module crash_monitor
(
	input  wire logic                  clk200,
	input  wire logic                  reset,
	input  wire race_pkg::game_state_t game_state,
	input  wire logic                  anim_tick,
	input  wire race_pkg::coord_t      player_x,
	input  wire race_pkg::coord_t      player_y,
	input  wire race_pkg::coord_t      obstacle_x [race_pkg::NUM_OBSTACLES],
	input  wire race_pkg::coord_t      obstacle_y [race_pkg::NUM_OBSTACLES],
	output logic [race_pkg::NUM_OBSTACLES-1:0] collide,
	output logic                       crashed,
	output logic                       explode_visible,
	output race_pkg::coord_t           explode_x,
	output race_pkg::coord_t           explode_y,
	output logic [3:0]                 explode_frame
);
	logic first_hit;
	logic frame_wrap;

	// ==========================================================================
	// Hitbox overlap
	// ==========================================================================
	// Player spans [y, y+CAR_H), obstacle spans [y-CAR_H, y).
	// Obstacle bound moved to the player side to avoid a negative top edge.
	always_comb
	begin
		for (int i = 0; i < race_pkg::NUM_OBSTACLES; i++)
		begin
			collide[i] = (game_state == race_pkg::ACTIVE) &&
				(player_x + race_pkg::HIT_LEFT <
					obstacle_x[i] + race_pkg::CAR_W - race_pkg::HIT_RIGHT) &&
				(obstacle_x[i] + race_pkg::HIT_LEFT <
					player_x + race_pkg::CAR_W - race_pkg::HIT_RIGHT) &&
				(player_y < obstacle_y[i]) &&
				(obstacle_y[i] < player_y + 2 * race_pkg::CAR_H);
		end
	end

	assign first_hit  = (|collide) && !crashed;
	assign frame_wrap = (explode_frame == race_pkg::EXPLODE_FRAMES - 1);

	// Explosion animation, still running once the game is over
	always_ff @(posedge clk200)
	begin
		if (reset)
		begin
			crashed         <= 1'b0;
			explode_visible <= 1'b0;
			explode_frame   <= '0;
		end
		else if (first_hit)
		begin
			crashed         <= 1'b1;
			explode_visible <= 1'b1;
			explode_frame   <= 4'd1;
		end
		else if (crashed && anim_tick)
		begin
			if (frame_wrap)
			begin
				explode_frame   <= '0;
				explode_visible <= 1'b0;
			end
			else
				explode_frame <= explode_frame + 4'd1;
		end
	end

	// Explosion placed over the player car
	always_ff @(posedge clk200)
	begin
		if (first_hit)
		begin
			explode_x <= player_x + race_pkg::EXPLODE_DX;
			explode_y <= player_y + race_pkg::EXPLODE_DY;
		end
	end

endmodule

`default_nettype wire

/* rtl/key_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module key_decoder
(
	input  wire logic             clk200,
	input  wire logic             reset,
	input  wire logic             key_valid,
	input  wire logic [7:0]       key_code,
	input  wire logic             key_break,
	input  wire logic             crashed,
	output race_pkg::game_state_t game_state,
	output race_pkg::steer_t      steer
);
	logic make_event;
	logic break_event;

	assign make_event  = key_valid && !key_break;
	assign break_event = key_valid && key_break;

	// ==========================================================================
	// Game state FSM
	// ==========================================================================
	always_ff @(posedge clk200)
	begin
		if (reset)
			game_state <= race_pkg::PREPARE;
		else
		begin
			case (game_state)
				race_pkg::PREPARE:
					if (break_event && key_code == race_pkg::KEY_START)
						game_state <= race_pkg::ACTIVE;
				race_pkg::ACTIVE:
					// A crash wins over a pause in the same cycle
					if (crashed)
						game_state <= race_pkg::OVER;
					else if (break_event && key_code == race_pkg::KEY_PAUSE)
						game_state <= race_pkg::PAUSED;
				race_pkg::PAUSED:
					if (break_event && key_code == race_pkg::KEY_PAUSE)
						game_state <= race_pkg::ACTIVE;
				default:
					// OVER is left only through reset
					game_state <= race_pkg::OVER;
			endcase
		end
	end

	// Held steering direction, dropped on any key release
	always_ff @(posedge clk200)
	begin
		if (reset || break_event)
			steer <= race_pkg::STEER_NONE;
		else if (make_event)
		begin
			case (key_code)
				race_pkg::KEY_UP:    steer <= race_pkg::STEER_UP;
				race_pkg::KEY_DOWN:  steer <= race_pkg::STEER_DOWN;
				race_pkg::KEY_LEFT:  steer <= race_pkg::STEER_LEFT;
				race_pkg::KEY_RIGHT: steer <= race_pkg::STEER_RIGHT;
				default:             steer <= steer;
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/obstacle_field.sv */
`timescale 1ns/1ps
`default_nettype none

module obstacle_field
(
	input  wire logic                               clk200,
	input  wire logic                               reset,
	input  wire race_pkg::game_state_t              game_state,
	input  wire race_pkg::steer_t                   steer,
	input  wire logic                               fall_tick,
	input  wire logic [race_pkg::NUM_OBSTACLES-1:0] collide,
	output race_pkg::coord_t                        obstacle_x [race_pkg::NUM_OBSTACLES],
	output race_pkg::coord_t                        obstacle_y [race_pkg::NUM_OBSTACLES]
);
	logic [race_pkg::LANE_CNT_W-1:0]    lane_cnt;
	logic [2:0]                         lane_idx;
	race_pkg::coord_t                   spawn_x;
	logic [race_pkg::NUM_OBSTACLES-1:0] due;
	logic [race_pkg::NUM_OBSTACLES-1:0] spawn;
	logic                               active;
	logic                               fall_en;

	assign active  = (game_state == race_pkg::ACTIVE);
	assign fall_en = fall_tick && active;

	// ==========================================================================
	// Lane counter
	// ==========================================================================
	// Runs every active cycle, so the lane depends on key timing
	always_ff @(posedge clk200)
	begin
		if (reset)
			lane_cnt <= '0;
		else if (active)
		begin
			if (steer != race_pkg::STEER_NONE)
				lane_cnt <= lane_cnt + race_pkg::LANE_CNT_W'(race_pkg::STEER_LANE_STEP);
			else
				lane_cnt <= lane_cnt + 1'b1;
		end
	end

	assign lane_idx = 3'(lane_cnt % race_pkg::LANE_CNT_W'(race_pkg::NUM_LANES));
	assign spawn_x  = race_pkg::lane_x(int'(lane_idx));

	// ==========================================================================
	// Respawn selection
	// ==========================================================================
	// All respawns on one tick share the same lane, so at most one is granted,
	// the lowest index first. The others wait for a later fall tick.
	always_comb
	begin
		logic taken;
		logic blocked;

		taken = 1'b0;
		for (int i = 0; i < race_pkg::NUM_OBSTACLES; i++)
		begin
			blocked = 1'b0;
			for (int j = 0; j < race_pkg::NUM_OBSTACLES; j++)
			begin
				if (j != i && obstacle_x[j] == spawn_x &&
					obstacle_y[j] <= race_pkg::SPAWN_GAP)
					blocked = 1'b1;
			end
			due[i]   = (obstacle_y[i] > race_pkg::FALL_LIMIT) || collide[i];
			spawn[i] = due[i] && !blocked && !taken;
			taken    = taken || spawn[i];
		end
	end

	// ==========================================================================
	// Positions
	// ==========================================================================
	always_ff @(posedge clk200)
	begin
		if (reset)
		begin
			for (int i = 0; i < race_pkg::NUM_OBSTACLES; i++)
			begin
				obstacle_x[i] <= race_pkg::lane_x(i);
				obstacle_y[i] <= race_pkg::OBSTACLE_Y0;
			end
		end
		else if (fall_en)
		begin
			for (int i = 0; i < race_pkg::NUM_OBSTACLES; i++)
			begin
				if (spawn[i])
				begin
					obstacle_x[i] <= spawn_x;
					obstacle_y[i] <= '0;
				end
				// A blocked respawn holds its place until the lane clears
				else if (!due[i])
					obstacle_y[i] <= obstacle_y[i] + race_pkg::FALL_STEP[i];
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/player_car.sv */
`timescale 1ns/1ps
`default_nettype none

module player_car
(
	input  wire logic                  clk200,
	input  wire logic                  reset,
	input  wire race_pkg::game_state_t game_state,
	input  wire race_pkg::steer_t      steer,
	input  wire logic                  move_tick,
	output race_pkg::coord_t           player_x,
	output race_pkg::coord_t           player_y
);
	logic step_en;

	assign step_en = move_tick && (game_state == race_pkg::ACTIVE);

	// ==========================================================================
	// One pixel per move tick, each axis checked only in its direction of travel
	// ==========================================================================
	always_ff @(posedge clk200)
	begin
		if (reset)
		begin
			player_x <= race_pkg::PLAYER_X0;
			player_y <= race_pkg::PLAYER_Y0;
		end
		else if (step_en)
		begin
			case (steer)
				race_pkg::STEER_UP:
				begin
					if (player_y > 0)
						player_y <= player_y - race_pkg::coord_t'(1);
				end
				race_pkg::STEER_DOWN:
				begin
					if (player_y < race_pkg::PLAYER_Y_MAX)
						player_y <= player_y + race_pkg::coord_t'(1);
				end
				race_pkg::STEER_LEFT:
				begin
					if (player_x > race_pkg::PLAYER_X_MIN)
						player_x <= player_x - race_pkg::coord_t'(1);
				end
				race_pkg::STEER_RIGHT:
				begin
					if (player_x < race_pkg::PLAYER_X_MAX)
						player_x <= player_x + race_pkg::coord_t'(1);
				end
				default:
				begin
					player_x <= player_x;
					player_y <= player_y;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/race_pkg.sv */
`default_nettype none

package race_pkg;

	// ==========================================================================
	// Coordinate and state types
	// ==========================================================================
	localparam int COORD_W = 10;

	typedef logic [COORD_W-1:0] coord_t;

	typedef enum logic [1:0]
	{
		PREPARE,
		ACTIVE,
		PAUSED,
		OVER
	} game_state_t;

	typedef enum logic [2:0]
	{
		STEER_NONE,
		STEER_UP,
		STEER_DOWN,
		STEER_LEFT,
		STEER_RIGHT
	} steer_t;

	// ==========================================================================
	// Screen, road and sprite geometry
	// ==========================================================================
	localparam int NUM_OBSTACLES = 5;
	localparam int NUM_LANES     = 5;
	localparam int SCREEN_H      = 480;
	localparam int ROAD_LEFT     = 79;
	localparam int LANE_W        = 96;

	localparam int CAR_W     = 60;
	localparam int CAR_H     = 100;
	localparam int HIT_LEFT  = 15;
	localparam int HIT_RIGHT = 5;

	localparam int EXPLODE_W      = 60;
	localparam int EXPLODE_H      = 60;
	localparam int EXPLODE_FRAMES = 14;
	// Explosion sprite centred on the car sprite
	localparam coord_t EXPLODE_DX = coord_t'((CAR_W - EXPLODE_W) / 2);
	localparam coord_t EXPLODE_DY = coord_t'((CAR_H - EXPLODE_H) / 2);

	localparam coord_t PLAYER_X0    = 289;
	localparam coord_t PLAYER_Y0    = 384;
	localparam int     PLAYER_X_MIN = 64;
	localparam int     PLAYER_X_MAX = 505;
	localparam int     PLAYER_Y_MAX = 380;

	// Obstacle y is the bottom edge of the sprite
	localparam coord_t OBSTACLE_Y0 = 100;
	localparam int     FALL_LIMIT  = SCREEN_H + CAR_H;
	localparam int     SPAWN_GAP   = 2 * CAR_H;
	localparam coord_t FALL_STEP [NUM_OBSTACLES] = '{4, 4, 3, 3, 2};

	// ==========================================================================
	// Timing and lane selection
	// ==========================================================================
	localparam int MOVE_DIV  = 4;
	localparam int FALL_DIV  = 32;
	localparam int ANIM_DIV  = 128;
	localparam int NUM_TICKS = 3;
	localparam int TICK_DIV [NUM_TICKS] = '{MOVE_DIV, FALL_DIV, ANIM_DIV};

	localparam int LANE_CNT_W      = 32;
	localparam int STEER_LANE_STEP = 1023;

	// Scan codes
	localparam logic [7:0] KEY_START = 8'h29;
	localparam logic [7:0] KEY_PAUSE = 8'h76;
	localparam logic [7:0] KEY_UP    = 8'h1D;
	localparam logic [7:0] KEY_DOWN  = 8'h1B;
	localparam logic [7:0] KEY_LEFT  = 8'h1C;
	localparam logic [7:0] KEY_RIGHT = 8'h23;

	// Left x of a car centred in lane k
	function automatic coord_t lane_x(input int k);
		return coord_t'(ROAD_LEFT + (LANE_W * (2 * k + 1) - CAR_W) / 2);
	endfunction

endpackage

`default_nettype wire

/* rtl/race_top.sv */
`timescale 1ns/1ps
`default_nettype none

module race_top
(
	input  wire logic                               clk200,
	input  wire logic                               reset,
	input  wire logic                               key_valid,
	input  wire logic [7:0]                         key_code,
	input  wire logic                               key_break,
	output wire race_pkg::game_state_t              game_state,
	output wire race_pkg::coord_t                   player_x,
	output wire race_pkg::coord_t                   player_y,
	output wire race_pkg::coord_t                   obstacle_x [race_pkg::NUM_OBSTACLES],
	output wire race_pkg::coord_t                   obstacle_y [race_pkg::NUM_OBSTACLES],
	output wire logic [race_pkg::NUM_OBSTACLES-1:0] collide,
	output wire logic                               explode_visible,
	output wire race_pkg::coord_t                   explode_x,
	output wire race_pkg::coord_t                   explode_y,
	output wire logic [3:0]                         explode_frame
);
	wire race_pkg::steer_t steer;
	wire logic             move_tick;
	wire logic             fall_tick;
	wire logic             anim_tick;
	wire logic             crashed;

	key_decoder u_key_decoder
	(
		.clk200     (clk200),
		.reset      (reset),
		.key_valid  (key_valid),
		.key_code   (key_code),
		.key_break  (key_break),
		.crashed    (crashed),
		.game_state (game_state),
		.steer      (steer)
	);

	tick_gen u_tick_gen
	(
		.clk200    (clk200),
		.reset     (reset),
		.move_tick (move_tick),
		.fall_tick (fall_tick),
		.anim_tick (anim_tick)
	);

	player_car u_player_car
	(
		.clk200     (clk200),
		.reset      (reset),
		.game_state (game_state),
		.steer      (steer),
		.move_tick  (move_tick),
		.player_x   (player_x),
		.player_y   (player_y)
	);

	obstacle_field u_obstacle_field
	(
		.clk200     (clk200),
		.reset      (reset),
		.game_state (game_state),
		.steer      (steer),
		.fall_tick  (fall_tick),
		.collide    (collide),
		.obstacle_x (obstacle_x),
		.obstacle_y (obstacle_y)
	);

	crash_monitor u_crash_monitor
	(
		.clk200          (clk200),
		.reset           (reset),
		.game_state      (game_state),
		.anim_tick       (anim_tick),
		.player_x        (player_x),
		.player_y        (player_y),
		.obstacle_x      (obstacle_x),
		.obstacle_y      (obstacle_y),
		.collide         (collide),
		.crashed         (crashed),
		.explode_visible (explode_visible),
		.explode_x       (explode_x),
		.explode_y       (explode_y),
		.explode_frame   (explode_frame)
	);

endmodule

`default_nettype wire

/* rtl/tick_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tick_gen
(
	input  wire logic clk200,
	input  wire logic reset,
	output logic      move_tick,
	output logic      fall_tick,
	output logic      anim_tick
);
	// Bit order follows TICK_DIV: move, fall, anim
	logic [race_pkg::NUM_TICKS-1:0] tick;

	for (genvar g = 0; g < race_pkg::NUM_TICKS; g++)
	begin : g_div
		logic [$clog2(race_pkg::TICK_DIV[g])-1:0] cnt;
		logic                                     strobe;
		logic                                     wrap;

		assign wrap    = (int'(cnt) == race_pkg::TICK_DIV[g] - 1);
		assign tick[g] = strobe;

		always_ff @(posedge clk200)
		begin
			if (reset)
			begin
				cnt    <= '0;
				strobe <= 1'b0;
			end
			else
			begin
				cnt    <= wrap ? '0 : cnt + 1'b1;
				strobe <= wrap;
			end
		end
	end

	assign move_tick = tick[0];
	assign fall_tick = tick[1];
	assign anim_tick = tick[2];

endmodule

`default_nettype wire

/* tests/race_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module race_chk
(
	input wire logic                               clk200,
	input wire logic                               reset,
	input wire race_pkg::game_state_t              game_state,
	input wire logic [race_pkg::NUM_OBSTACLES-1:0] collide,
	input wire logic [3:0]                         explode_frame
);
	// OVER is terminal until reset
	over_held: assert property (@(posedge clk200) disable iff (reset)
		game_state == race_pkg::OVER |=> game_state == race_pkg::OVER)
		else $error("game_state left OVER without a reset");

	collide_only_active: assert property (@(posedge clk200) disable iff (reset)
		game_state != race_pkg::ACTIVE |-> collide == '0)
		else $error("collide set while the game is not active");

	frame_in_range: assert property (@(posedge clk200) disable iff (reset)
		explode_frame < race_pkg::EXPLODE_FRAMES)
		else $error("explode_frame out of range");

endmodule

bind race_top race_chk i_chk
(
	.clk200        (clk200),
	.reset         (reset),
	.game_state    (game_state),
	.collide       (collide),
	.explode_frame (explode_frame)
);

`default_nettype wire

/* tests/race_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module race_tb;

	// Values taken from the game rules
	localparam int LANE_X [race_pkg::NUM_LANES]      = '{97, 193, 289, 385, 481};
	localparam int FALL_PX [race_pkg::NUM_OBSTACLES] = '{4, 4, 3, 3, 2};
	localparam int START_X          = 289;
	localparam int START_Y          = 384;
	localparam int START_OBSTACLE_Y = 100;
	localparam int SPAWN_CLEAR      = 2 * race_pkg::CAR_H;
	// Midway between lanes 0 and 1, out of reach of every lane hitbox
	localparam int SAFE_X = 145;

	localparam int RESET_CYCLES = 16;
	localparam int KEY_GAP_MAX  = 8;
	localparam int KEY_COST     = 1 + KEY_GAP_MAX;
	localparam int PAUSE_HOLD   = 300;
	localparam int BOUND_HOLD   = 40;
	localparam int LEFT_WAIT    = race_pkg::MOVE_DIV * (START_X - race_pkg::PLAYER_X_MIN + 10);
	localparam int SIDE_WAIT    = race_pkg::MOVE_DIV * (SAFE_X - race_pkg::PLAYER_X_MIN + 10);
	localparam int UP_WAIT      = race_pkg::MOVE_DIV * (START_Y + 10);
	localparam int FALL_WAIT    = 4000;
	localparam int MIN_RESPAWNS = 2;
	localparam int AIM_TRIES    = 4;
	localparam int AIM_WAIT     =
		race_pkg::MOVE_DIV * (race_pkg::PLAYER_X_MAX - race_pkg::PLAYER_X_MIN + 10);
	localparam int DOWN_WAIT    = 3000;
	localparam int OVER_WAIT    = 10;
	localparam int ANIM_WAIT    = race_pkg::EXPLODE_FRAMES * race_pkg::ANIM_DIV + 50;
	localparam int CYCLE_LIMIT  = 2 * (RESET_CYCLES + 20 * KEY_COST + PAUSE_HOLD
		+ LEFT_WAIT + SIDE_WAIT + UP_WAIT + 2 * BOUND_HOLD + FALL_WAIT
		+ AIM_TRIES * (AIM_WAIT + DOWN_WAIT + 3 * KEY_COST) + OVER_WAIT + ANIM_WAIT) + 100;

	logic                               clk200 = 1'b0;
	logic                               reset;
	logic                               key_valid;
	logic [7:0]                         key_code;
	logic                               key_break;
	race_pkg::game_state_t              game_state;
	race_pkg::coord_t                   player_x;
	race_pkg::coord_t                   player_y;
	race_pkg::coord_t                   obstacle_x [race_pkg::NUM_OBSTACLES];
	race_pkg::coord_t                   obstacle_y [race_pkg::NUM_OBSTACLES];
	logic [race_pkg::NUM_OBSTACLES-1:0] collide;
	logic                               explode_visible;
	race_pkg::coord_t                   explode_x;
	race_pkg::coord_t                   explode_y;
	logic [3:0]                         explode_frame;

	integer seed;
	int     cycles = 0;
	int     checks = 0;
	int     errors = 0;
	int     test_start_errors = 0;
	int     respawns = 0;
	bit     mon_on = 1'b0;
	bit     have_prev = 1'b0;
	bit     hit_seen = 1'b0;
	bit     anim_done = 1'b0;

	race_pkg::coord_t      hit_px;
	race_pkg::coord_t      hit_py;
	race_pkg::coord_t      prev_px;
	race_pkg::coord_t      prev_py;
	race_pkg::coord_t      prev_ox [race_pkg::NUM_OBSTACLES];
	race_pkg::coord_t      prev_oy [race_pkg::NUM_OBSTACLES];
	race_pkg::game_state_t prev_state;
	logic [3:0]            prev_frame;

	always #10 clk200 = ~clk200;

	race_top i_dut
	(
		.clk200          (clk200),
		.reset           (reset),
		.key_valid       (key_valid),
		.key_code        (key_code),
		.key_break       (key_break),
		.game_state      (game_state),
		.player_x        (player_x),
		.player_y        (player_y),
		.obstacle_x      (obstacle_x),
		.obstacle_y      (obstacle_y),
		.collide         (collide),
		.explode_visible (explode_visible),
		.explode_x       (explode_x),
		.explode_y       (explode_y),
		.explode_frame   (explode_frame)
	);

	// ==========================================================================
	// Compare tasks and helpers
	// ==========================================================================
	task automatic check_state(input string name, input race_pkg::game_state_t expected,
		input race_pkg::game_state_t actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("Mismatch at %0t: %s expected %s, got %s", $time, name,
				expected.name(), actual.name());
		end
	endtask

	task automatic check_coord(input string name, input race_pkg::coord_t expected,
		input race_pkg::coord_t actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("Mismatch at %0t: %s expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	task automatic note_error(input string msg);
		errors++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	task automatic start_test();
		test_start_errors = errors;
	endtask

	task automatic finish_test(input string name);
		$display("test %s: %0d errors", name, errors - test_start_errors);
	endtask

	// One key strobe, then a random idle gap; called on a falling edge
	task automatic send_key(input logic [7:0] code, input logic release_key);
		int gap;
		key_code  = code;
		key_break = release_key;
		key_valid = 1'b1;
		@(negedge clk200);
		key_valid = 1'b0;
		key_break = 1'b0;
		gap = 1 + {$random(seed)} % KEY_GAP_MAX;
		repeat (gap) @(negedge clk200);
	endtask

	// Hitbox model: player spans [py, py+CAR_H), obstacle spans [oy-CAR_H, oy)
	function automatic bit boxes_overlap(input int px, input int py, input int ox, input int oy);
		int p_left;
		int p_right;
		int o_left;
		int o_right;
		p_left  = px + race_pkg::HIT_LEFT;
		p_right = px + race_pkg::CAR_W - race_pkg::HIT_RIGHT;
		o_left  = ox + race_pkg::HIT_LEFT;
		o_right = ox + race_pkg::CAR_W - race_pkg::HIT_RIGHT;
		return (p_left < o_right) && (o_left < p_right) &&
			(py < oy) && (oy - race_pkg::CAR_H < py + race_pkg::CAR_H);
	endfunction

	// ==========================================================================
	// Cycle monitor
	// ==========================================================================
	always @(negedge clk200)
	begin : monitor
		int dx;
		int dy;
		bit exp_hit;
		bit in_lane;
		bit gap_ok;
		if (!mon_on)
			have_prev = 1'b0;
		else
		begin
			for (int i = 0; i < race_pkg::NUM_OBSTACLES; i++)
			begin
				exp_hit = (game_state == race_pkg::ACTIVE) &&
					boxes_overlap(player_x, player_y, obstacle_x[i], obstacle_y[i]);
				check_bit($sformatf("collide[%0d]", i), exp_hit, collide[i]);
			end
			// Explosion stays hidden once its frames have run back to 0
			if (have_prev && prev_frame != 4'd0 && explode_frame == 4'd0)
				anim_done = 1'b1;
			check_bit("explode_visible", explode_frame != 4'd0 && !anim_done, explode_visible);
			if (collide != '0 && !hit_seen)
			begin
				hit_seen = 1'b1;
				hit_px   = player_x;
				hit_py   = player_y;
			end
			if (have_prev)
			begin
				dx = int'(player_x) - int'(prev_px);
				dy = int'(player_y) - int'(prev_py);
				if ((dx != 0 || dy != 0) && prev_state != race_pkg::ACTIVE)
					note_error("player moved while the game was not active");
				else if (dx * dx + dy * dy > 1)
					note_error($sformatf("player moved by (%0d, %0d) in one cycle", dx, dy));
				for (int i = 0; i < race_pkg::NUM_OBSTACLES; i++)
				begin
					if (obstacle_x[i] != prev_ox[i] || obstacle_y[i] != prev_oy[i])
					begin
						if (prev_state != race_pkg::ACTIVE)
							note_error($sformatf("obstacle %0d moved while not active", i));
						else if (obstacle_y[i] == 0)
						begin
							respawns++;
							in_lane = 1'b0;
							gap_ok  = 1'b1;
							for (int k = 0; k < race_pkg::NUM_LANES; k++)
								if (obstacle_x[i] == LANE_X[k])
									in_lane = 1'b1;
							for (int j = 0; j < race_pkg::NUM_OBSTACLES; j++)
								if (j != i && prev_ox[j] == obstacle_x[i] &&
									prev_oy[j] <= SPAWN_CLEAR)
									gap_ok = 1'b0;
							if (!in_lane)
								note_error($sformatf("obstacle %0d respawned off the lanes", i));
							if (!gap_ok)
								note_error($sformatf("obstacle %0d respawned too close", i));
						end
						else
						begin
							check_coord($sformatf("obstacle_y[%0d]", i),
								race_pkg::coord_t'(prev_oy[i] + FALL_PX[i]), obstacle_y[i]);
							check_coord($sformatf("obstacle_x[%0d]", i), prev_ox[i],
								obstacle_x[i]);
						end
					end
				end
				if (explode_frame != prev_frame)
					check_coord("explode_frame",
						race_pkg::coord_t'((prev_frame + 1) % race_pkg::EXPLODE_FRAMES),
						race_pkg::coord_t'(explode_frame));
			end
			prev_px    = player_x;
			prev_py    = player_y;
			prev_ox    = obstacle_x;
			prev_oy    = obstacle_y;
			prev_state = game_state;
			prev_frame = explode_frame;
			have_prev  = 1'b1;
		end
	end

	always @(posedge clk200)
	begin
		cycles++;
		if (cycles == CYCLE_LIMIT)
		begin
			$display("timeout: run stopped after %0d cycles", cycles);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// ==========================================================================
	// Directed tests
	// ==========================================================================
	task automatic reset_values();
		start_test();
		check_state("game_state", race_pkg::PREPARE, game_state);
		check_coord("player_x", START_X, player_x);
		check_coord("player_y", START_Y, player_y);
		check_bit("explode_visible", 1'b0, explode_visible);
		check_coord("explode_frame", 0, race_pkg::coord_t'(explode_frame));
		for (int i = 0; i < race_pkg::NUM_OBSTACLES; i++)
		begin
			check_coord($sformatf("obstacle_x[%0d]", i), LANE_X[i], obstacle_x[i]);
			check_coord($sformatf("obstacle_y[%0d]", i), START_OBSTACLE_Y, obstacle_y[i]);
		end
		finish_test("reset_values");
	endtask

	task automatic start_and_pause();
		race_pkg::coord_t hold_px;
		race_pkg::coord_t hold_py;
		race_pkg::coord_t hold_oy [race_pkg::NUM_OBSTACLES];
		start_test();
		// A make alone must not start the game
		send_key(race_pkg::KEY_START, 1'b0);
		check_state("game_state", race_pkg::PREPARE, game_state);
		send_key(race_pkg::KEY_START, 1'b1);
		check_state("game_state", race_pkg::ACTIVE, game_state);
		send_key(race_pkg::KEY_PAUSE, 1'b1);
		check_state("game_state", race_pkg::PAUSED, game_state);
		hold_px = player_x;
		hold_py = player_y;
		hold_oy = obstacle_y;
		repeat (PAUSE_HOLD) @(negedge clk200);
		check_coord("player_x", hold_px, player_x);
		check_coord("player_y", hold_py, player_y);
		for (int i = 0; i < race_pkg::NUM_OBSTACLES; i++)
			check_coord($sformatf("obstacle_y[%0d]", i), hold_oy[i], obstacle_y[i]);
		send_key(race_pkg::KEY_PAUSE, 1'b1);
		check_state("game_state", race_pkg::ACTIVE, game_state);
		finish_test("start_and_pause");
	endtask

	task automatic steering_and_bounds();
		int n;
		race_pkg::coord_t start_py;
		race_pkg::coord_t col_x;
		start_test();
		start_py = player_y;
		send_key(race_pkg::KEY_LEFT, 1'b0);
		n = 0;
		while (player_x != race_pkg::PLAYER_X_MIN && n < LEFT_WAIT)
		begin
			@(negedge clk200);
			n++;
		end
		repeat (BOUND_HOLD) @(negedge clk200);
		send_key(race_pkg::KEY_LEFT, 1'b1);
		check_coord("player_x", race_pkg::PLAYER_X_MIN, player_x);
		check_coord("player_y", start_py, player_y);

		// Park in the gap between lanes before climbing
		send_key(race_pkg::KEY_RIGHT, 1'b0);
		n = 0;
		while (player_x < SAFE_X && n < SIDE_WAIT)
		begin
			@(negedge clk200);
			n++;
		end
		send_key(race_pkg::KEY_RIGHT, 1'b1);
		if (player_x < SAFE_X)
			note_error("player never reached the gap between lanes");
		col_x = player_x;
		send_key(race_pkg::KEY_UP, 1'b0);
		n = 0;
		while (player_y != 0 && n < UP_WAIT)
		begin
			@(negedge clk200);
			n++;
		end
		repeat (BOUND_HOLD) @(negedge clk200);
		send_key(race_pkg::KEY_UP, 1'b1);
		check_coord("player_y", 0, player_y);
		check_coord("player_x", col_x, player_x);
		check_state("game_state", race_pkg::ACTIVE, game_state);
		finish_test("steering_and_bounds");
	endtask

	task automatic obstacle_motion();
		int n;
		int first_count;
		start_test();
		first_count = respawns;
		n = 0;
		while (respawns < first_count + MIN_RESPAWNS && n < FALL_WAIT)
		begin
			@(negedge clk200);
			n++;
		end
		if (respawns < first_count + MIN_RESPAWNS)
			note_error("too few obstacle respawns while the game was active");
		check_state("game_state", race_pkg::ACTIVE, game_state);
		finish_test("obstacle_motion");
	endtask

	task automatic crash_and_explode();
		int n;
		int tries;
		int k;
		logic [7:0] side_key;
		race_pkg::coord_t aim_x;
		race_pkg::coord_t hold_px;
		race_pkg::coord_t hold_py;
		race_pkg::coord_t hold_ox [race_pkg::NUM_OBSTACLES];
		race_pkg::coord_t hold_oy [race_pkg::NUM_OBSTACLES];
		start_test();
		tries = 0;
		while (!hit_seen && tries < AIM_TRIES)
		begin
			// Chase the car nearest the top, then drive down into it
			k = 0;
			for (int i = 1; i < race_pkg::NUM_OBSTACLES; i++)
				if (obstacle_y[i] < obstacle_y[k])
					k = i;
			aim_x = obstacle_x[k];
			if (player_x != aim_x)
			begin
				side_key = (player_x < aim_x) ? race_pkg::KEY_RIGHT : race_pkg::KEY_LEFT;
				send_key(side_key, 1'b0);
				n = 0;
				while (!hit_seen && player_x != aim_x && n < AIM_WAIT)
				begin
					@(negedge clk200);
					n++;
				end
				send_key(side_key, 1'b1);
			end
			send_key(race_pkg::KEY_DOWN, 1'b0);
			n = 0;
			while (!hit_seen && n < DOWN_WAIT)
			begin
				@(negedge clk200);
				n++;
			end
			send_key(race_pkg::KEY_DOWN, 1'b1);
			tries++;
		end
		if (!hit_seen)
			note_error("no collision after steering into the lanes");
		else
		begin
			n = 0;
			while (game_state != race_pkg::OVER && n < OVER_WAIT)
			begin
				@(negedge clk200);
				n++;
			end
			check_state("game_state", race_pkg::OVER, game_state);
			check_coord("explode_x",
				race_pkg::coord_t'(hit_px + (race_pkg::CAR_W - race_pkg::EXPLODE_W) / 2),
				explode_x);
			check_coord("explode_y",
				race_pkg::coord_t'(hit_py + (race_pkg::CAR_H - race_pkg::EXPLODE_H) / 2),
				explode_y);
			check_bit("explode_visible", 1'b1, explode_visible);
			hold_px = player_x;
			hold_py = player_y;
			hold_ox = obstacle_x;
			hold_oy = obstacle_y;
			n = 0;
			while (explode_frame != 4'd0 && n < ANIM_WAIT)
			begin
				@(negedge clk200);
				n++;
			end
			if (explode_frame != 4'd0)
				note_error("explosion animation never returned to frame 0");
			check_bit("explode_visible", 1'b0, explode_visible);
			check_state("game_state", race_pkg::OVER, game_state);
			check_coord("player_x", hold_px, player_x);
			check_coord("player_y", hold_py, player_y);
			for (int i = 0; i < race_pkg::NUM_OBSTACLES; i++)
			begin
				check_coord($sformatf("obstacle_x[%0d]", i), hold_ox[i], obstacle_x[i]);
				check_coord($sformatf("obstacle_y[%0d]", i), hold_oy[i], obstacle_y[i]);
			end
		end
		finish_test("crash_and_explode");
	endtask

	// ==========================================================================
	// Main sequence
	// ==========================================================================
	initial
	begin
		seed      = 32'ha751e254;
		reset     = 1'b1;
		key_valid = 1'b0;
		key_code  = 8'h00;
		key_break = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk200);
		@(negedge clk200);
		reset  = 1'b0;
		mon_on = 1'b1;

		reset_values();
		start_and_pause();
		steering_and_bounds();
		obstacle_motion();
		crash_and_explode();

		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
